//--- wb_host_pkg.sv
package wb_host_pkg;

   // ------------------------------------------------------------------------
   // Bus widths
   // ------------------------------------------------------------------------
   parameter int ADDR_W = 32;              // Master and slave address
   parameter int DATA_W = 32;              // Data bus
   parameter int SEL_W  = 4;               // Byte enables
   parameter int BANK_W = 8;               // Bank select field
   parameter int OFFS_W = 20;              // Master bits passed to slave

   // Region field in the master address
   parameter int REGION_MSB = 23;
   parameter int REGION_LSB = 22;

   // Local register index bits
   parameter int REG_IDX_MSB = 3;
   parameter int REG_IDX_LSB = 2;

   // ------------------------------------------------------------------------
   // Global control fields
   // ------------------------------------------------------------------------
   parameter int GLB_WB_RST_BIT   = 0;     // Internal wishbone soft reset
   parameter int GLB_BIST_RST_BIT = 1;     // BIST soft reset

   // Byte 1 was the clock divider field, now reserved
   parameter logic [DATA_W-1:0] GLB_USED_MASK = 32'hFFFF_00FF;

   // Address region decode
   typedef enum logic [1:0] {
      REGION_EXT0 = 2'b00,                 // Lower extended window
      REGION_EXT1 = 2'b01,                 // Upper extended window
      REGION_HOST = 2'b10,                 // Local register block
      REGION_TEST = 2'b11                  // Logic test window, answered with err
   } region_e;

   // Local register words
   typedef enum logic [1:0] {
      REG_GLB_CTRL  = 2'b00,
      REG_BANK_SEL  = 2'b01,
      REG_CLK_CTRL1 = 2'b10,
      REG_CLK_CTRL2 = 2'b11
   } reg_idx_e;

endpackage

//--- wb_host_front.sv
`timescale 1ns/1ps

module wb_host_front
   import wb_host_pkg::*;
(
   input  logic                         wbm_clk_i,
   input  logic                         wbm_rst_n,
   input  logic                         wbm_stb_i,    // Strobe, already qualified by cyc
   input  logic [REGION_MSB:REGION_LSB] wbm_adr_i,    // Region bits only
   input  logic                         reg_ack_i,
   input  logic [DATA_W-1:0]            reg_rdata_i,
   input  logic                         ext_ack_i,
   input  logic                         ext_err_i,
   input  logic [DATA_W-1:0]            ext_rdata_i,
   output logic                         host_req_o,   // One cycle pulse to register block
   output logic                         ext_req_o,    // One cycle pulse to outbound path
   output logic [DATA_W-1:0]            wbm_dat_o,
   output logic                         wbm_ack_o,
   output logic                         wbm_err_o
);

   region_e           region;
   logic              wb_req;      // Captured strobe
   logic              req_busy;    // Request issued, response pending
   logic              issue;
   logic              is_host;
   logic              is_ext;
   logic              test_req;    // Test window request, answered locally
   logic              resp_ack;
   logic              resp_err;
   logic [DATA_W-1:0] resp_dat;

   // ------------------------------------------------------------------------
   // Request capture
   // ------------------------------------------------------------------------
   // Strobe is blocked while a response is on its way or was just given,
   // so the master has time to drop stb before it is seen again
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         wb_req   <= 1'b0;
         req_busy <= 1'b0;
      end
      else
      begin
         wb_req   <= wbm_stb_i & ~wbm_ack_o & ~resp_ack;
         req_busy <= (req_busy | issue) & ~resp_ack;   // Cleared by the response
      end
   end

   assign issue = wb_req & ~req_busy & ~resp_ack;       // First cycle of a new request

   // Region decode
   assign region = region_e'(wbm_adr_i);

   always_comb
   begin
      is_host = 1'b0;
      is_ext  = 1'b0;
      case (region)
         REGION_EXT0, REGION_EXT1: is_ext  = 1'b1;
         REGION_HOST:              is_host = 1'b1;
         default:                  ;                    // Test window, handled below
      endcase
   end

   // Steered request pulses, one per request
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         host_req_o <= 1'b0;
         ext_req_o  <= 1'b0;
         test_req   <= 1'b0;
      end
      else
      begin
         host_req_o <= issue & is_host;
         ext_req_o  <= issue & is_ext;
         test_req   <= issue & ~is_host & ~is_ext;
      end
   end

   // ------------------------------------------------------------------------
   // Response select and output register
   // ------------------------------------------------------------------------
   always_comb
   begin
      resp_ack = reg_ack_i | ext_ack_i | test_req;
      resp_dat = '0;
      resp_err = 1'b0;
      if (reg_ack_i)
      begin
         resp_dat = reg_rdata_i;            // Local registers never error
      end
      else if (ext_ack_i)
      begin
         resp_dat = ext_rdata_i;
         resp_err = ext_err_i;
      end
      else if (test_req)
      begin
         resp_err = 1'b1;                   // No logic engine behind this window
      end
   end

   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         wbm_ack_o <= 1'b0;
         wbm_dat_o <= '0;
         wbm_err_o <= 1'b0;
      end
      else
      begin
         wbm_ack_o <= resp_ack;
         if (resp_ack)
         begin
            wbm_dat_o <= resp_dat;          // Data and err hold between responses
            wbm_err_o <= resp_err;
         end
      end
   end

endmodule

//--- wb_host_regs.sv
`timescale 1ns/1ps

module wb_host_regs
   import wb_host_pkg::*;
#(
   parameter logic [DATA_W-1:0] GLB_RST_VAL = '0     // Global control after reset
)
(
   input  logic                           wbm_clk_i,
   input  logic                           wbm_rst_n,
   input  logic                           host_req_i,  // One cycle access pulse
   input  logic [REG_IDX_MSB:REG_IDX_LSB] wbm_adr_i,   // Word index
   input  logic                           wbm_we_i,
   input  logic [DATA_W-1:0]              wbm_dat_i,
   input  logic [SEL_W-1:0]               wbm_sel_i,
   output logic                           reg_ack_o,
   output logic [DATA_W-1:0]              reg_rdata_o,
   output logic [BANK_W-1:0]              bank_sel_o,
   output logic                           wbd_int_rst_n_o,
   output logic                           bist_rst_n_o,
   output logic [DATA_W-1:0]              cfg_clk_ctrl1_o,
   output logic [DATA_W-1:0]              cfg_clk_ctrl2_o
);

   // Reserved byte never leaves reset at anything but zero
   localparam logic [DATA_W-1:0] GLB_RST_USED = GLB_RST_VAL & GLB_USED_MASK;

   reg_idx_e          reg_idx;
   logic              wr_en;
   logic              rd_en;
   logic [DATA_W-1:0] glb_ctrl;
   logic [DATA_W-1:0] rd_mux;

   assign reg_idx = reg_idx_e'(wbm_adr_i);
   assign wr_en   = host_req_i & wbm_we_i;
   assign rd_en   = host_req_i & ~wbm_we_i;

   // ------------------------------------------------------------------------
   // Global control, byte enabled
   // ------------------------------------------------------------------------
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         glb_ctrl <= GLB_RST_USED;
      end
      else if (wr_en && (reg_idx == REG_GLB_CTRL))
      begin
         for (int b = 0; b < SEL_W; b++)
         begin
            if (wbm_sel_i[b])
            begin
               glb_ctrl[8*b +: 8] <= wbm_dat_i[8*b +: 8] & GLB_USED_MASK[8*b +: 8];
            end
         end
      end
   end

   assign wbd_int_rst_n_o = glb_ctrl[GLB_WB_RST_BIT];    // Soft resets, active low
   assign bist_rst_n_o    = glb_ctrl[GLB_BIST_RST_BIT];

   // ------------------------------------------------------------------------
   // Bank select and clock control, whole word writes
   // ------------------------------------------------------------------------
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         bank_sel_o      <= '0;
         cfg_clk_ctrl1_o <= '0;
         cfg_clk_ctrl2_o <= '0;
      end
      else if (wr_en)
      begin
         case (reg_idx)
            REG_BANK_SEL:  bank_sel_o      <= wbm_dat_i[BANK_W-1:0];
            REG_CLK_CTRL1: cfg_clk_ctrl1_o <= wbm_dat_i;
            REG_CLK_CTRL2: cfg_clk_ctrl2_o <= wbm_dat_i;
            default:       ;                   // Global control handled above
         endcase
      end
   end

   // Read mux
   always_comb
   begin
      case (reg_idx)
         REG_GLB_CTRL:  rd_mux = glb_ctrl;
         REG_BANK_SEL:  rd_mux = {{(DATA_W-BANK_W){1'b0}}, bank_sel_o};
         REG_CLK_CTRL1: rd_mux = cfg_clk_ctrl1_o;
         REG_CLK_CTRL2: rd_mux = cfg_clk_ctrl2_o;
         default:       rd_mux = '0;
      endcase
   end

   // One cycle ack for every access, reads registered
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         reg_ack_o   <= 1'b0;
         reg_rdata_o <= '0;
      end
      else
      begin
         reg_ack_o <= host_req_i;
         if (rd_en)
         begin
            reg_rdata_o <= rd_mux;
         end
      end
   end

endmodule

//--- wb_host_fwd.sv
`timescale 1ns/1ps

module wb_host_fwd
   import wb_host_pkg::*;
(
   input  logic              wbm_clk_i,
   input  logic              wbm_rst_n,
   input  logic              ext_req_i,     // One cycle launch pulse
   input  logic [BANK_W-1:0] bank_sel_i,
   input  logic [OFFS_W-1:0] wbm_adr_i,     // Offset within the bank
   input  logic              wbm_we_i,
   input  logic [DATA_W-1:0] wbm_dat_i,
   input  logic [SEL_W-1:0]  wbm_sel_i,
   input  logic [DATA_W-1:0] wbs_dat_i,
   input  logic              wbs_ack_i,
   input  logic              wbs_err_i,
   output logic              ext_ack_o,     // Response pulse back to front end
   output logic              ext_err_o,
   output logic [DATA_W-1:0] ext_rdata_o,
   output logic              wbs_cyc_o,
   output logic              wbs_stb_o,
   output logic [ADDR_W-1:0] wbs_adr_o,
   output logic              wbs_we_o,
   output logic [DATA_W-1:0] wbs_dat_o,
   output logic [SEL_W-1:0]  wbs_sel_o
);

   localparam int PAD_W = ADDR_W - BANK_W - OFFS_W;   // Zero bits on top

   logic launch;
   logic done;

   assign launch = ext_req_i & ~wbs_cyc_o;            // Only one cycle in flight
   assign done   = wbs_cyc_o & (wbs_ack_i | wbs_err_i);

   // ------------------------------------------------------------------------
   // Slave cycle control
   // ------------------------------------------------------------------------
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         wbs_cyc_o   <= 1'b0;
         wbs_stb_o   <= 1'b0;
         ext_ack_o   <= 1'b0;
         ext_err_o   <= 1'b0;
         ext_rdata_o <= '0;
      end
      else
      begin
         if (launch)
         begin
            wbs_cyc_o <= 1'b1;
            wbs_stb_o <= 1'b1;
         end
         else if (done)
         begin
            wbs_cyc_o <= 1'b0;                        // Ends on the ack edge
            wbs_stb_o <= 1'b0;
         end
         ext_ack_o <= done;                           // Err also counts as a response
         ext_err_o <= done & wbs_err_i;
         if (done)
         begin
            ext_rdata_o <= wbs_dat_i;
         end
      end
   end

   // Request fields, held for the whole cycle
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         wbs_adr_o <= '0;
         wbs_we_o  <= 1'b0;
         wbs_dat_o <= '0;
         wbs_sel_o <= '0;
      end
      else if (launch)
      begin
         wbs_adr_o <= {{PAD_W{1'b0}}, bank_sel_i, wbm_adr_i};
         wbs_we_o  <= wbm_we_i;
         wbs_dat_o <= wbm_dat_i;
         wbs_sel_o <= wbm_sel_i;
      end
   end

endmodule

//--- wb_host_top.sv
`timescale 1ns/1ps

module wb_host_top
   import wb_host_pkg::*;
#(
   parameter logic [DATA_W-1:0] GLB_RST_VAL = '0
)
(
   input  logic              wbm_clk_i,
   input  logic              wbm_rst_n,
   // Master port
   input  logic              wbm_cyc_i,
   input  logic              wbm_stb_i,
   input  logic [ADDR_W-1:0] wbm_adr_i,
   input  logic              wbm_we_i,
   input  logic [DATA_W-1:0] wbm_dat_i,
   input  logic [SEL_W-1:0]  wbm_sel_i,
   output logic [DATA_W-1:0] wbm_dat_o,
   output logic              wbm_ack_o,
   output logic              wbm_err_o,
   // Slave port
   output logic              wbs_cyc_o,
   output logic              wbs_stb_o,
   output logic [ADDR_W-1:0] wbs_adr_o,
   output logic              wbs_we_o,
   output logic [DATA_W-1:0] wbs_dat_o,
   output logic [SEL_W-1:0]  wbs_sel_o,
   input  logic [DATA_W-1:0] wbs_dat_i,
   input  logic              wbs_ack_i,
   input  logic              wbs_err_i,
   // Soft resets and clock control
   output logic              wbd_int_rst_n_o,
   output logic              bist_rst_n_o,
   output logic [DATA_W-1:0] cfg_clk_ctrl1_o,
   output logic [DATA_W-1:0] cfg_clk_ctrl2_o
);

   logic              wbm_req;        // Strobe inside an open cycle
   logic              host_req;
   logic              ext_req;
   logic              reg_ack;
   logic [DATA_W-1:0] reg_rdata;
   logic              ext_ack;
   logic              ext_err;
   logic [DATA_W-1:0] ext_rdata;
   logic [BANK_W-1:0] bank_sel;

   assign wbm_req = wbm_cyc_i & wbm_stb_i;

   // Front end, decode and response register
   wb_host_front u_front (
      .wbm_clk_i   (wbm_clk_i),   .wbm_rst_n   (wbm_rst_n),
      .wbm_stb_i   (wbm_req),     .wbm_adr_i   (wbm_adr_i[REGION_MSB:REGION_LSB]),
      .reg_ack_i   (reg_ack),     .reg_rdata_i (reg_rdata),
      .ext_ack_i   (ext_ack),     .ext_err_i   (ext_err),
      .ext_rdata_i (ext_rdata),   .host_req_o  (host_req),
      .ext_req_o   (ext_req),     .wbm_dat_o   (wbm_dat_o),
      .wbm_ack_o   (wbm_ack_o),   .wbm_err_o   (wbm_err_o)
   );

   // Local registers
   wb_host_regs #(.GLB_RST_VAL(GLB_RST_VAL)) u_regs (
      .wbm_clk_i       (wbm_clk_i),        .wbm_rst_n       (wbm_rst_n),
      .host_req_i      (host_req),         .wbm_adr_i       (wbm_adr_i[REG_IDX_MSB:REG_IDX_LSB]),
      .wbm_we_i        (wbm_we_i),         .wbm_dat_i       (wbm_dat_i),
      .wbm_sel_i       (wbm_sel_i),        .reg_ack_o       (reg_ack),
      .reg_rdata_o     (reg_rdata),        .bank_sel_o      (bank_sel),
      .wbd_int_rst_n_o (wbd_int_rst_n_o),  .bist_rst_n_o    (bist_rst_n_o),
      .cfg_clk_ctrl1_o (cfg_clk_ctrl1_o),  .cfg_clk_ctrl2_o (cfg_clk_ctrl2_o)
   );

   // Outbound path, bank extended address
   wb_host_fwd u_fwd (
      .wbm_clk_i  (wbm_clk_i),  .wbm_rst_n   (wbm_rst_n),   .ext_req_i (ext_req),
      .bank_sel_i (bank_sel),   .wbm_adr_i   (wbm_adr_i[OFFS_W-1:0]),
      .wbm_we_i   (wbm_we_i),   .wbm_dat_i   (wbm_dat_i),   .wbm_sel_i (wbm_sel_i),
      .wbs_dat_i  (wbs_dat_i),  .wbs_ack_i   (wbs_ack_i),   .wbs_err_i (wbs_err_i),
      .ext_ack_o  (ext_ack),    .ext_err_o   (ext_err),     .ext_rdata_o (ext_rdata),
      .wbs_cyc_o  (wbs_cyc_o),  .wbs_stb_o   (wbs_stb_o),   .wbs_adr_o (wbs_adr_o),
      .wbs_we_o   (wbs_we_o),   .wbs_dat_o   (wbs_dat_o),   .wbs_sel_o (wbs_sel_o)
   );

endmodule

//--- wb_host_props.sv
`timescale 1ns/1ps

module wb_host_props
   import wb_host_pkg::*;
(
   input logic              wbm_clk_i,
   input logic              wbm_rst_n,
   input logic [ADDR_W-1:0] wbm_adr_i,   // Master address, held until ack
   input logic              mst_ack_i,   // Bridge ack toward the master
   input logic              slv_cyc_i,
   input logic              slv_stb_i,
   input logic [ADDR_W-1:0] slv_adr_i,
   input logic              slv_we_i,
   input logic [DATA_W-1:0] slv_dat_i,
   input logic [SEL_W-1:0]  slv_sel_i,
   input logic              slv_ack_i,
   input logic              slv_err_i
);

   // ------------------------------------------------------------------------
   // Master side
   // ------------------------------------------------------------------------
   ack_one_cycle: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      mst_ack_i |=> !mst_ack_i)
      else $error("wbm_ack_o stayed high for two cycles");

   // ------------------------------------------------------------------------
   // Slave side
   // ------------------------------------------------------------------------
   stb_in_cyc: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      slv_stb_i |-> slv_cyc_i)
      else $error("wbs_stb_o high outside a wbs_cyc_o cycle");

   // Fields frozen until the slave answers
   slv_stable: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      (slv_stb_i && !slv_ack_i && !slv_err_i) |=>
         (slv_stb_i && $stable(slv_adr_i) && $stable(slv_we_i) &&
          $stable(slv_dat_i) && $stable(slv_sel_i)))
      else $error("slave request changed or dropped before ack");

   // Only the two extended windows may open a slave cycle
   ext_only: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      $rose(slv_cyc_i) |->
         (wbm_adr_i[REGION_MSB:REGION_LSB] == REGION_EXT0 ||
          wbm_adr_i[REGION_MSB:REGION_LSB] == REGION_EXT1))
      else $error("slave cycle started for a host or test region address");

endmodule

bind wb_host_top wb_host_props u_props (
   .wbm_clk_i (wbm_clk_i),  .wbm_rst_n (wbm_rst_n),  .wbm_adr_i (wbm_adr_i),
   .mst_ack_i (wbm_ack_o),  .slv_cyc_i (wbs_cyc_o),  .slv_stb_i (wbs_stb_o),
   .slv_adr_i (wbs_adr_o),  .slv_we_i  (wbs_we_o),   .slv_dat_i (wbs_dat_o),
   .slv_sel_i (wbs_sel_o),  .slv_ack_i (wbs_ack_i),  .slv_err_i (wbs_err_i)
);

//--- tb_wb_host.sv
`timescale 1ns/1ps

module tb_wb_host
   import wb_host_pkg::*;
();

   localparam int          TIMEOUT_CYC = 50;              // Max cycles per access
   localparam logic [31:0] NO_SLAVE    = 32'hFFFF_FFFF;   // Golden marker, no slave cycle
   localparam logic [31:0] FILL_KEY    = 32'hA5A5_A5A5;   // Unwritten slave words

   logic              wbm_clk_i, wbm_rst_n;
   logic              wbm_cyc_i, wbm_stb_i, wbm_we_i;
   logic [ADDR_W-1:0] wbm_adr_i;
   logic [DATA_W-1:0] wbm_dat_i, wbm_dat_o;
   logic [SEL_W-1:0]  wbm_sel_i;
   logic              wbm_ack_o, wbm_err_o;
   logic              wbs_cyc_o, wbs_stb_o, wbs_we_o;
   logic [ADDR_W-1:0] wbs_adr_o;
   logic [DATA_W-1:0] wbs_dat_o, wbs_dat_i;
   logic [SEL_W-1:0]  wbs_sel_o;
   logic              wbs_ack_i, wbs_err_i;
   logic              wbd_int_rst_n_o, bist_rst_n_o;
   logic [DATA_W-1:0] cfg_clk_ctrl1_o, cfg_clk_ctrl2_o;

   logic [DATA_W-1:0] slv_mem [logic [ADDR_W-1:0]];      // Slave storage by full address
   logic [ADDR_W-1:0] slv_adr_seen;                       // Last slave address launched
   logic [SEL_W-1:0]  slv_sel_seen;                       // Byte enables of that cycle
   int                slv_count;                          // Slave cycles seen
   int                n_checks, n_mismatch, n_other;
   int                line_no;
   logic              timed_out;                          // Stops the golden loop

   wb_host_top #(.GLB_RST_VAL(32'h0)) wb_host_top_i (.*);

   initial
   begin
      wbm_clk_i = 1'b0;
      forever #4 wbm_clk_i = ~wbm_clk_i;   // 8 ns period
   end

   // ------------------------------------------------------------------------
   // Slave model, random wait of 0 to 3 cycles
   // ------------------------------------------------------------------------
   initial
   begin
      int unsigned       wait_cyc;
      logic [ADDR_W-1:0] s_adr;
      wbs_dat_i    = '0;
      wbs_ack_i    = 1'b0;
      wbs_err_i    = 1'b0;
      slv_count    = 0;
      slv_adr_seen = '0;
      slv_sel_seen = '0;
      wait_cyc     = $urandom(71);         // Seed once
      forever
      begin
         @(posedge wbm_clk_i);
         #1;
         if (wbs_cyc_o && wbs_stb_o)
         begin
            s_adr        = wbs_adr_o;
            slv_adr_seen = s_adr;
            slv_sel_seen = wbs_sel_o;
            slv_count++;
            wait_cyc = $urandom % 4;
            repeat (wait_cyc)
            begin
               @(posedge wbm_clk_i);
               #1;
            end
            if (s_adr[19])
            begin
               wbs_err_i = 1'b1;            // Error window of the slave
               wbs_dat_i = '0;
            end
            else
            begin
               wbs_ack_i = 1'b1;
               if (wbs_we_o)
               begin
                  slv_mem[s_adr] = wbs_dat_o;
                  wbs_dat_i      = '0;
               end
               else
               begin
                  wbs_dat_i = slv_mem.exists(s_adr) ? slv_mem[s_adr] : (s_adr ^ FILL_KEY);
               end
            end
            @(posedge wbm_clk_i);            // Bridge samples the answer here
            #1;
            wbs_ack_i = 1'b0;
            wbs_err_i = 1'b0;
         end
      end
   end

   task automatic print_counts();
      $display("Checks %0d, mismatches %0d, other errors %0d", n_checks, n_mismatch, n_other);
   endtask

   task automatic check_val(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
      n_checks++;
      if (actual !== expected)
      begin
         n_mismatch++;
         $display("mismatch %s (golden line %0d): got %h, expected %h",
                  name, line_no, actual, expected);
      end
   endtask

   // One master access, returns data, err and edges until ack seen
   task automatic wb_access(input logic [31:0] adr, input logic w, input logic [31:0] wdat,
                            input logic [3:0] bsel, output logic [31:0] rdat,
                            output logic rerr, output int edges);
      logic got;
      got   = 1'b0;
      edges = 0;
      rdat  = '0;
      rerr  = 1'b0;
      wbm_cyc_i = 1'b1;
      wbm_stb_i = 1'b1;
      wbm_adr_i = adr;
      wbm_we_i  = w;
      wbm_dat_i = wdat;
      wbm_sel_i = bsel;
      while (!got && edges < TIMEOUT_CYC)
      begin
         @(posedge wbm_clk_i);
         #1;
         edges++;
         got = wbm_ack_o;
      end
      if (!got)
      begin
         n_other++;
         timed_out = 1'b1;
         $display("ERROR: no ack for address %h within %0d cycles", adr, TIMEOUT_CYC);
      end
      else
      begin
         rdat      = wbm_dat_o;
         rerr      = wbm_err_o;
         wbm_cyc_i = 1'b0;
         wbm_stb_i = 1'b0;
         @(posedge wbm_clk_i);               // Idle cycle, ack falls
         #1;
      end
   endtask

   // ------------------------------------------------------------------------
   // One golden line
   // ------------------------------------------------------------------------
   task automatic run_line(input logic [31:0] op, input logic [31:0] adr,
                           input logic [31:0] wdat, input logic [31:0] bsel,
                           input logic [31:0] exp_rd, input logic [31:0] exp_err,
                           input logic [31:0] exp_sadr);
      logic [31:0] rdat;
      logic        rerr;
      int          edges;
      int          cnt_before;
      case (op)
         0, 1:
         begin
            cnt_before = slv_count;
            wb_access(adr, op[0], wdat, bsel[3:0], rdat, rerr, edges);
            if (!timed_out)
            begin
               check_val("wbm_err_o", rerr, exp_err);
               if (op == 0)
                  check_val("wbm_dat_o", rdat, exp_rd);
               if (exp_sadr == NO_SLAVE)
                  check_val("slave cycle count", slv_count, cnt_before);
               else
               begin
                  check_val("slave cycle count", slv_count, cnt_before + 1);
                  check_val("wbs_adr_o", slv_adr_seen, exp_sadr);
                  check_val("wbs_sel_o", slv_sel_seen, bsel);
               end
               case (adr[REGION_MSB:REGION_LSB])   // Edges after stb first sampled
                  REGION_HOST: check_val("host ack latency", edges - 1, 3);
                  REGION_TEST: check_val("test ack latency", edges - 1, 2);
                  default:     ;
               endcase
            end
         end
         2:
         begin
            check_val("cfg_clk_ctrl1_o", cfg_clk_ctrl1_o, wdat);
            check_val("cfg_clk_ctrl2_o", cfg_clk_ctrl2_o, exp_rd);
            check_val("soft resets", {30'b0, bist_rst_n_o, wbd_int_rst_n_o}, bsel);
         end
         default:
         begin
            n_other++;
            $display("ERROR: unknown operation %h on golden line %0d", op, line_no);
         end
      endcase
   endtask

   initial
   begin
      int          fd;
      int          code;
      string       line_txt;
      logic [31:0] op, adr, wdat, bsel, exp_rd, exp_err, exp_sadr;
      n_checks   = 0;
      n_mismatch = 0;
      n_other    = 0;
      line_no    = 0;
      timed_out  = 1'b0;
      wbm_rst_n  = 1'b0;
      wbm_cyc_i  = 1'b0;
      wbm_stb_i  = 1'b0;
      wbm_adr_i  = '0;
      wbm_we_i   = 1'b0;
      wbm_dat_i  = '0;
      wbm_sel_i  = '0;
      repeat (5) @(posedge wbm_clk_i);        // Reset for 5 cycles
      #1;
      wbm_rst_n = 1'b1;
      @(posedge wbm_clk_i);
      #1;
      fd = $fopen("wb_host_golden.txt", "r");
      if (fd == 0)
      begin
         n_other++;
         $display("ERROR: could not open wb_host_golden.txt");
      end
      else
      begin
         while (!$feof(fd) && !timed_out)
         begin
            code = $fgets(line_txt, fd);
            line_no++;
            if (code > 0 && line_txt.len() > 1 && line_txt[0] != "#")
            begin
               code = $sscanf(line_txt, "%h %h %h %h %h %h %h",
                              op, adr, wdat, bsel, exp_rd, exp_err, exp_sadr);
               if (code != 7)
               begin
                  n_other++;
                  $display("ERROR: golden line %0d has the wrong format", line_no);
               end
               else
               begin
                  run_line(op, adr, wdat, bsel, exp_rd, exp_err, exp_sadr);
               end
            end
         end
         $fclose(fd);
      end
      print_counts();
      if (n_checks > 0 && n_mismatch == 0 && n_other == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

//--- verilog.f
wb_host_pkg.sv
wb_host_front.sv
wb_host_regs.sv
wb_host_fwd.sv
wb_host_top.sv
wb_host_props.sv
tb_wb_host.sv

//--- wb_host_golden.txt
# op: 0 read, 1 write, 2 check outputs (wdata clk ctrl1, rdata clk ctrl2, sel {bist, wbd} rst)
# op addr wdata sel rdata err slave_addr, all hex, slave_addr ffffffff means no slave cycle
# Local registers after reset
0 00800000 00000000 f 00000000 0 ffffffff
0 00800004 00000000 f 00000000 0 ffffffff
0 00800008 00000000 f 00000000 0 ffffffff
0 0080000c 00000000 f 00000000 0 ffffffff
2 00000000 00000000 0 00000000 0 ffffffff
# Global control byte enables and soft resets
1 00800000 12345603 1 00000000 0 ffffffff
0 00800000 00000000 f 00000003 0 ffffffff
2 00000000 00000000 3 00000000 0 ffffffff
1 00800000 aabbccdd 6 00000000 0 ffffffff
0 00800000 00000000 f 00bb0003 0 ffffffff
1 00800000 0000ff02 1 00000000 0 ffffffff
2 00000000 00000000 2 00000000 0 ffffffff
1 00800000 ffffffff 8 00000000 0 ffffffff
0 00800000 00000000 f ffbb0002 0 ffffffff
1 00800000 00000001 f 00000000 0 ffffffff
0 00800000 00000000 f 00000001 0 ffffffff
2 00000000 00000000 1 00000000 0 ffffffff
# Clock control words
1 00800008 deadbeef f 00000000 0 ffffffff
1 0080000c 0badf00d 3 00000000 0 ffffffff
0 00800008 00000000 f deadbeef 0 ffffffff
0 0080000c 00000000 f 0badf00d 0 ffffffff
2 00000000 deadbeef 1 0badf00d 0 ffffffff
# Bank select and extended accesses
1 00800004 ffffff12 f 00000000 0 ffffffff
0 00800004 00000000 f 00000012 0 ffffffff
1 00001230 11111111 f 00000000 0 01201230
1 00445678 55aa55aa f 00000000 0 01245678
1 00800004 00000034 f 00000000 0 ffffffff
1 00001230 22222222 f 00000000 0 03401230
0 00001230 00000000 f 22222222 0 03401230
1 00800004 00000012 f 00000000 0 ffffffff
0 00001230 00000000 f 11111111 0 01201230
0 00445678 00000000 f 55aa55aa 0 01245678
0 00002000 00000000 f a48585a5 0 01202000
# Slave errors and test region
1 00080010 01020304 f 00000000 1 01280010
0 000f0000 00000000 f 00000000 1 012f0000
0 00c00000 00000000 f 00000000 1 ffffffff
1 00c00004 cafef00d f 00000000 1 ffffffff
0 00800004 00000000 f 00000012 0 ffffffff
# More extended traffic under random slave waits
1 00000100 a0a0a0a1 f 00000000 0 01200100
1 00000104 b0b0b0b2 f 00000000 0 01200104
1 0037fffc c0c0c0c3 f 00000000 0 0127fffc
0 00000100 00000000 f a0a0a0a1 0 01200100
0 00000104 00000000 f b0b0b0b2 0 01200104
0 0037fffc 00000000 f c0c0c0c3 0 0127fffc
